// ==== logic/rv_pkg.sv ====
// rv_pkg: shared widths and control encodings for the RV64I multicycle core
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    ALU_ADD     = 4'b0000,
    ALU_COPYIMM = 4'b0011,
    ALU_SUB     = 4'b1000,
    ALU_ADDW    = 4'b1001,
    ALU_SLTU    = 4'b1010,
    ALU_EBREAK  = 4'b1110,
    ALU_NONE    = 4'b1111
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BNE  = 3'b101
  } branch_t;

  typedef enum logic [2:0] {
    MEM_SB   = 3'b000,
    MEM_UB   = 3'b001,
    MEM_SH   = 3'b010,
    MEM_UH   = 3'b011,
    MEM_SW   = 3'b100,
    MEM_UW   = 3'b101,
    MEM_SD   = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_t;

  typedef enum logic {
    ALU_A_RS1 = 1'b0,
    ALU_A_PC  = 1'b1
  } alu_a_t;

  typedef enum logic [1:0] {
    ALU_B_RS2  = 2'b00,
    ALU_B_IMM  = 2'b01,
    ALU_B_FOUR = 2'b10
  } alu_b_t;

endpackage

`default_nettype wire

// ==== logic/rv_idu.sv ====
// rv_idu: instruction decoder producing immediate, register indices and control fields
`timescale 1ns/1ns
`default_nettype none

module rv_idu (
  input  wire logic [31:0]           i_inst,
  output logic [rv_pkg::XLEN-1:0]    o_imm,
  output logic [4:0]                 o_ra,
  output logic [4:0]                 o_rb,
  output logic [4:0]                 o_rd,
  output rv_pkg::branch_t            o_branch,
  output logic                       o_reg_wr,
  output rv_pkg::alu_a_t             o_alu_a_src,
  output rv_pkg::alu_b_t             o_alu_b_src,
  output rv_pkg::alu_op_t            o_alu_op,
  output logic                       o_mem_to_reg,
  output logic                       o_mem_wr,
  output rv_pkg::mem_op_t            o_mem_op,
  output logic                       o_is_ebreak
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [rv_pkg::XLEN-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;
  logic is_lui, is_auipc, is_jal, is_jalr, is_bne, is_lw, is_sw, is_sd;
  logic is_addi, is_sltiu, is_add, is_sub, is_addiw, is_addw, is_ebreak;
  logic form_r, form_i, form_u, form_s, form_b, form_j;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign is_lui    = (opcode == rv_pkg::OP_LUI);
  assign is_auipc  = (opcode == rv_pkg::OP_AUIPC);
  assign is_jal    = (opcode == rv_pkg::OP_JAL);
  assign is_jalr   = (opcode == rv_pkg::OP_JALR) && (funct3 == 3'b000);
  assign is_bne    = (opcode == rv_pkg::OP_BRANCH) && (funct3 == 3'b001);
  assign is_lw     = (opcode == rv_pkg::OP_LOAD) && (funct3 == 3'b010);
  assign is_sw     = (opcode == rv_pkg::OP_STORE) && (funct3 == 3'b010);
  assign is_sd     = (opcode == rv_pkg::OP_STORE) && (funct3 == 3'b011);
  assign is_addi   = (opcode == rv_pkg::OP_IMM) && (funct3 == 3'b000);
  assign is_sltiu  = (opcode == rv_pkg::OP_IMM) && (funct3 == 3'b011);
  assign is_addiw  = (opcode == rv_pkg::OP_IMM32) && (funct3 == 3'b000);
  assign is_add    = (opcode == rv_pkg::OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign is_sub    = (opcode == rv_pkg::OP_REG) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign is_addw   = (opcode == rv_pkg::OP_REG32) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  // ebreak is the system encoding with imm = 1 and all other fields zero
  assign is_ebreak = (opcode == rv_pkg::OP_SYSTEM) && (i_inst[31:7] == 25'h0002000);

  assign form_r = is_add | is_sub | is_addw;
  assign form_i = is_lw | is_addi | is_sltiu | is_addiw | is_jalr | is_ebreak;
  assign form_u = is_lui | is_auipc;
  assign form_s = is_sw | is_sd;
  assign form_b = is_bne;
  assign form_j = is_jal;

  always_comb begin
    o_imm = '0;
    if (form_i) begin
      o_imm = imm_i;
    end else if (form_u) begin
      o_imm = imm_u;
    end else if (form_s) begin
      o_imm = imm_s;
    end else if (form_b) begin
      o_imm = imm_b;
    end else if (form_j) begin
      o_imm = imm_j;
    end
  end

  // ebreak writes nothing, so it is left out of the write set
  assign o_reg_wr     = form_r | form_u | form_j | (form_i & ~is_ebreak);
  assign o_mem_to_reg = is_lw;
  assign o_mem_wr     = form_s;
  assign o_is_ebreak  = is_ebreak;

  // pc feeds the A side for anything computing a pc-relative value
  assign o_alu_a_src = (is_jal | is_auipc | is_jalr) ? rv_pkg::ALU_A_PC : rv_pkg::ALU_A_RS1;

  always_comb begin
    if (is_jal || is_jalr) begin
      o_alu_b_src = rv_pkg::ALU_B_FOUR;
    end else if (form_i || form_u || form_s) begin
      o_alu_b_src = rv_pkg::ALU_B_IMM;
    end else begin
      o_alu_b_src = rv_pkg::ALU_B_RS2;
    end
  end

  always_comb begin
    o_alu_op = rv_pkg::ALU_NONE;
    if (is_lui) begin
      o_alu_op = rv_pkg::ALU_COPYIMM;
    end else if (is_auipc || is_jal || is_jalr || is_lw || form_s || is_addi || is_add) begin
      o_alu_op = rv_pkg::ALU_ADD;
    end else if (is_addiw || is_addw) begin
      o_alu_op = rv_pkg::ALU_ADDW;
    end else if (is_bne || is_sub) begin
      o_alu_op = rv_pkg::ALU_SUB;
    end else if (is_sltiu) begin
      o_alu_op = rv_pkg::ALU_SLTU;
    end else if (is_ebreak) begin
      o_alu_op = rv_pkg::ALU_EBREAK;
    end
  end

  always_comb begin
    if (is_jal) begin
      o_branch = rv_pkg::BR_JAL;
    end else if (is_jalr) begin
      o_branch = rv_pkg::BR_JALR;
    end else if (is_bne) begin
      o_branch = rv_pkg::BR_BNE;
    end else begin
      o_branch = rv_pkg::BR_NONE;
    end
  end

  // only word and doubleword widths are decoded
  always_comb begin
    if (is_lw || is_sw) begin
      o_mem_op = rv_pkg::MEM_SW;
    end else if (is_sd) begin
      o_mem_op = rv_pkg::MEM_SD;
    end else begin
      o_mem_op = rv_pkg::MEM_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
// rv_alu: operand selection and integer operations, with the bne condition flag
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_t              i_op,
  input  rv_pkg::alu_a_t               i_a_src,
  input  rv_pkg::alu_b_t               i_b_src,
  input  wire logic [rv_pkg::XLEN-1:0] i_rs1,
  input  wire logic [rv_pkg::XLEN-1:0] i_rs2,
  input  wire logic [rv_pkg::XLEN-1:0] i_pc,
  input  wire logic [rv_pkg::XLEN-1:0] i_imm,
  output logic [rv_pkg::XLEN-1:0]      o_result,
  output logic                         o_taken
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] sum;
  logic [rv_pkg::XLEN-1:0] diff;
  logic [31:0]             sum_w;

  assign op_a = (i_a_src == rv_pkg::ALU_A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_b_src)
      rv_pkg::ALU_B_RS2:  op_b = i_rs2;
      rv_pkg::ALU_B_IMM:  op_b = i_imm;
      rv_pkg::ALU_B_FOUR: op_b = 64'd4;
      default:            op_b = '0;
    endcase
  end

  assign sum   = op_a + op_b;
  assign diff  = op_a - op_b;
  assign sum_w = op_a[31:0] + op_b[31:0];

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:     o_result = sum;
      rv_pkg::ALU_SUB:     o_result = diff;
      rv_pkg::ALU_COPYIMM: o_result = i_imm;
      rv_pkg::ALU_ADDW:    o_result = {{32{sum_w[31]}}, sum_w};
      rv_pkg::ALU_SLTU:    o_result = {63'd0, op_a < op_b};
      // ebreak and unknown encodings produce nothing
      default:             o_result = '0;
    endcase
  end

  // rs1 != rs2 when both operands come from registers
  assign o_taken = |diff;

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
// rv_regfile: 32 x 64-bit integer registers, two async reads and one sync write
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  input  wire logic                    i_we,
  input  wire logic [4:0]              i_waddr,
  input  wire logic [4:0]              i_raddr_a,
  input  wire logic [4:0]              i_raddr_b,
  input  wire logic [rv_pkg::XLEN-1:0] i_wdata,
  output logic [rv_pkg::XLEN-1:0]      o_rdata_a,
  output logic [rv_pkg::XLEN-1:0]      o_rdata_b
);

  logic [rv_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 stays zero because writes to it are dropped
  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

  a_x0_zero: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_raddr_a == 5'd0) |-> (o_rdata_a == '0));

endmodule

`default_nettype wire

// ==== logic/rv_lsu.sv ====
// rv_lsu: store lane placement with byte enables and load extraction with sign extension
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
  input  rv_pkg::mem_op_t              i_op,
  input  wire logic [rv_pkg::XLEN-1:0] i_addr,
  input  wire logic [rv_pkg::XLEN-1:0] i_store_data,
  input  wire logic [rv_pkg::XLEN-1:0] i_load_raw,
  output logic [rv_pkg::XLEN-1:0]      o_wdata,
  output logic [7:0]                   o_be,
  output logic [rv_pkg::XLEN-1:0]      o_load_data
);

  logic        upper;
  logic [31:0] word;

  // address bit 2 picks the half of the doubleword
  assign upper = i_addr[2];
  assign word  = upper ? i_load_raw[63:32] : i_load_raw[31:0];

  always_comb begin
    o_wdata     = '0;
    o_be        = 8'h00;
    o_load_data = '0;
    case (i_op)
      rv_pkg::MEM_SW, rv_pkg::MEM_UW: begin
        o_wdata     = {2{i_store_data[31:0]}};
        o_be        = upper ? 8'hF0 : 8'h0F;
        o_load_data = (i_op == rv_pkg::MEM_SW) ? {{32{word[31]}}, word} : {32'd0, word};
      end
      rv_pkg::MEM_SD: begin
        o_wdata     = i_store_data;
        o_be        = 8'hFF;
        o_load_data = i_load_raw;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_pc_unit.sv ====
// rv_pc_unit: program counter with reset value, sequential step and jump/branch targets
`timescale 1ns/1ns
`default_nettype none

module rv_pc_unit #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  input  wire logic                    i_step,
  input  rv_pkg::branch_t              i_branch,
  input  wire logic                    i_taken,
  input  wire logic [rv_pkg::XLEN-1:0] i_imm,
  input  wire logic [rv_pkg::XLEN-1:0] i_rs1,
  output logic [rv_pkg::XLEN-1:0]      o_pc
);

  logic [rv_pkg::XLEN-1:0] pc_next;
  logic [rv_pkg::XLEN-1:0] jalr_sum;

  assign jalr_sum = i_rs1 + i_imm;

  always_comb begin
    pc_next = o_pc + 64'd4;
    if ((i_branch == rv_pkg::BR_JAL) || ((i_branch == rv_pkg::BR_BNE) && i_taken)) begin
      pc_next = o_pc + i_imm;
    end else if (i_branch == rv_pkg::BR_JALR) begin
      pc_next = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_pc <= RESET_PC;
    end else if (i_step) begin
      o_pc <= pc_next;
    end
  end

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
    i_step |=> (o_pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== logic/rv_ctrl_fsm.sv ====
// rv_ctrl_fsm sequences fetch, latch, execute and memory phases and halts on ebreak
`timescale 1ns/1ns
`default_nettype none

module rv_ctrl_fsm (
  input  wire logic i_clk,
  input  wire logic i_reset,
  input  wire logic i_is_mem,
  input  wire logic i_is_ebreak,
  input  wire logic i_mem_wr,
  output logic      o_ir_load,
  output logic      o_mem_re,
  output logic      o_mem_we,
  output logic      o_rf_we_phase,
  output logic      o_retire,
  output logic      o_halt
);

  typedef enum logic [2:0] {
    S_FETCH = 3'd0,
    S_LATCH = 3'd1,
    S_EXEC  = 3'd2,
    S_MEM   = 3'd3,
    S_HALT  = 3'd4
  } state_t;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH: state_d = S_LATCH;
      S_LATCH: state_d = S_EXEC;
      S_EXEC: begin
        if (i_is_ebreak) begin
          state_d = S_HALT;
        end else if (i_is_mem) begin
          state_d = S_MEM;
        end else begin
          state_d = S_FETCH;
        end
      end
      S_MEM:   state_d = S_FETCH;
      S_HALT:  state_d = S_HALT;
      default: state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= S_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // instruction memory answers during LATCH
  assign o_ir_load = (state_q == S_LATCH);

  // strobes go out in the third cycle and data comes back in MEM
  assign o_mem_re = (state_q == S_EXEC) && i_is_mem && !i_mem_wr;
  assign o_mem_we = (state_q == S_EXEC) && i_is_mem && i_mem_wr;

  assign o_rf_we_phase = ((state_q == S_EXEC) && !i_is_mem) || (state_q == S_MEM);
  assign o_retire      = o_rf_we_phase;

  // high from the ebreak retire cycle onward
  assign o_halt = (state_q == S_HALT) || (o_retire && i_is_ebreak);

  // a single strobe is followed by the retiring MEM cycle
  a_strobe_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_mem_we || o_mem_re) |=> ($past(o_mem_we != o_mem_re) && o_retire));

  a_no_retire_halted: assert property (@(posedge i_clk) disable iff (i_reset)
    o_halt |=> (o_halt && !o_retire));

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
// rv_core: multicycle RV64I core joining decoder, ALU, registers, LSU, PC and control
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  input  wire logic [31:0]             i_imem_data,
  input  wire logic [rv_pkg::XLEN-1:0] i_dmem_rdata,
  output logic [rv_pkg::XLEN-1:0]      o_imem_addr,
  output logic [rv_pkg::XLEN-1:0]      o_dmem_addr,
  output logic [rv_pkg::XLEN-1:0]      o_dmem_wdata,
  output logic [7:0]                   o_dmem_be,
  output logic                         o_dmem_we,
  output logic                         o_dmem_re,
  output logic                         o_retire,
  output logic [rv_pkg::XLEN-1:0]      o_retire_pc,
  output logic                         o_wb_en,
  output logic [4:0]                   o_wb_rd,
  output logic [rv_pkg::XLEN-1:0]      o_wb_data,
  output logic                         o_halt
);

  logic [31:0]             ir;
  logic [rv_pkg::XLEN-1:0] pc, imm, rs1_data, rs2_data, alu_result, load_data;
  logic [4:0]              ra, rb, rd;
  rv_pkg::branch_t         branch;
  rv_pkg::alu_a_t          alu_a_src;
  rv_pkg::alu_b_t          alu_b_src;
  rv_pkg::alu_op_t         alu_op;
  rv_pkg::mem_op_t         mem_op;
  logic reg_wr, mem_to_reg, mem_wr, is_ebreak, taken, ir_load, rf_we_phase, rf_we;

  always_ff @(posedge i_clk) begin
    if (ir_load) begin
      ir <= i_imem_data;
    end
  end

  rv_idu u_idu (
    .i_inst(ir), .o_imm(imm), .o_ra(ra), .o_rb(rb), .o_rd(rd), .o_branch(branch),
    .o_reg_wr(reg_wr), .o_alu_a_src(alu_a_src), .o_alu_b_src(alu_b_src), .o_alu_op(alu_op),
    .o_mem_to_reg(mem_to_reg), .o_mem_wr(mem_wr), .o_mem_op(mem_op), .o_is_ebreak(is_ebreak)
  );

  rv_ctrl_fsm u_ctrl (
    .i_clk(i_clk), .i_reset(i_reset), .i_is_mem(mem_to_reg | mem_wr),
    .i_is_ebreak(is_ebreak), .i_mem_wr(mem_wr), .o_ir_load(ir_load), .o_mem_re(o_dmem_re),
    .o_mem_we(o_dmem_we), .o_rf_we_phase(rf_we_phase), .o_retire(o_retire), .o_halt(o_halt)
  );

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_reset(i_reset), .i_we(rf_we), .i_waddr(rd), .i_raddr_a(ra),
    .i_raddr_b(rb), .i_wdata(o_wb_data), .o_rdata_a(rs1_data), .o_rdata_b(rs2_data)
  );

  rv_alu u_alu (
    .i_op(alu_op), .i_a_src(alu_a_src), .i_b_src(alu_b_src), .i_rs1(rs1_data),
    .i_rs2(rs2_data), .i_pc(pc), .i_imm(imm), .o_result(alu_result), .o_taken(taken)
  );

  rv_lsu u_lsu (
    .i_op(mem_op), .i_addr(alu_result), .i_store_data(rs2_data), .i_load_raw(i_dmem_rdata),
    .o_wdata(o_dmem_wdata), .o_be(o_dmem_be), .o_load_data(load_data)
  );

  // the pc moves on the retire cycle
  rv_pc_unit #(.RESET_PC(RESET_PC)) u_pc (
    .i_clk(i_clk), .i_reset(i_reset), .i_step(o_retire), .i_branch(branch), .i_taken(taken),
    .i_imm(imm), .i_rs1(rs1_data), .o_pc(pc)
  );

  assign rf_we       = rf_we_phase & reg_wr;
  assign o_imem_addr = pc;
  assign o_dmem_addr = {alu_result[rv_pkg::XLEN-1:3], 3'b000};
  assign o_wb_data   = mem_to_reg ? load_data : alu_result;
  assign o_wb_en     = rf_we & (rd != 5'd0);
  assign o_wb_rd     = rd;
  assign o_retire_pc = pc;

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
// tb_rv_core checks the core against memory models and an ISA reference model
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam logic [63:0] RESET_PC     = 64'h0;
  localparam int          RESET_CYCLES = 10;
  localparam int          SEED         = 45599;
  localparam int          ROM_WORDS    = 64;
  localparam int          RAM_DW       = 64;

  logic        clk;
  logic        reset;
  logic [31:0] imem_data = '0;
  logic [63:0] dmem_rdata = '0;
  logic [63:0] imem_addr, dmem_addr, dmem_wdata, retire_pc, wb_data;
  logic [7:0]  dmem_be;
  logic        dmem_we, dmem_re, retire, wb_en, halt;
  logic [4:0]  wb_rd;

  logic [31:0] rom [ROM_WORDS];
  logic [63:0] ram [RAM_DW];
  int unsigned prog_len = 0;
  int unsigned errors = 0;
  int unsigned retired = 0;
  logic        prog_ready = 1'b0;

  // reference model state and the expected outcome of the instruction at m_pc
  logic [63:0] m_pc;
  logic [63:0] m_regs [32];
  logic [63:0] m_ram [RAM_DW];
  logic        m_halted;
  logic [31:0] m_inst;
  logic [4:0]  m_rd;
  logic [63:0] m_a, m_b, m_imm_i, m_imm_s, m_ea, m_ld_dw;
  logic [31:0] m_ld_w;
  logic        exp_wr, exp_wb_en, exp_store, exp_ebreak;
  logic [63:0] exp_data, exp_next_pc, exp_wdata, exp_addr;
  logic [7:0]  exp_be;

  rv_core #(.RESET_PC(RESET_PC)) dut0 (
    .i_clk(clk), .i_reset(reset), .i_imem_data(imem_data), .i_dmem_rdata(dmem_rdata),
    .o_imem_addr(imem_addr), .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
    .o_dmem_be(dmem_be), .o_dmem_we(dmem_we), .o_dmem_re(dmem_re), .o_retire(retire),
    .o_retire_pc(retire_pc), .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
    .o_halt(halt)
  );

  function automatic logic [63:0] fill_word(input int idx);
    return {32'hd000_0000 + idx, 32'h8000_0000 + idx * 8};
  endfunction

  function automatic logic [63:0] lane_mask(input logic [7:0] be);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  function automatic logic [63:0] sext_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] got,
      input logic [63:0] want);
    errors++;
    $display("** Error: %s = 0x%h, expected 0x%h at %0t ns", name, got, want, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_random_alu();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = 5'($urandom_range(0, 7));
    rs1 = 5'($urandom_range(1, 7));
    rs2 = 5'($urandom_range(0, 7));
    imm = 12'($urandom());
    case ($urandom_range(0, 5))
      0: emit(enc_r(7'h00, rs2, rs1, 3'b000, rd, rv_pkg::OP_REG));
      1: emit(enc_r(7'h20, rs2, rs1, 3'b000, rd, rv_pkg::OP_REG));
      2: emit(enc_r(7'h00, rs2, rs1, 3'b000, rd, rv_pkg::OP_REG32));
      3: emit(enc_i(imm, rs1, 3'b000, rd, rv_pkg::OP_IMM));
      4: emit(enc_i(imm, rs1, 3'b000, rd, rv_pkg::OP_IMM32));
      default: emit(enc_i(imm, rs1, 3'b011, rd, rv_pkg::OP_IMM));
    endcase
  endtask

  task automatic build_program();
    int unsigned off_w;
    int unsigned off_d;
    int unsigned off_r;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    // random starting values in x1..x7
    for (int r = 1; r < 8; r++) begin
      emit(enc_u(20'($urandom()), 5'(r), rv_pkg::OP_LUI));
      emit(enc_i(12'($urandom()), 5'(r), 3'b000, 5'(r), rv_pkg::OP_IMM));
    end
    repeat (8) emit_random_alu();
    // x0 is written and then read back through add
    emit(enc_i(12'h123, 5'd1, 3'b000, 5'd0, rv_pkg::OP_IMM));
    emit(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd5, rv_pkg::OP_REG));
    emit(enc_u(20'($urandom()), 5'd3, rv_pkg::OP_AUIPC));
    // jal and jalr each hop over one instruction
    emit(enc_j(21'd8, 5'd4, rv_pkg::OP_JAL));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd4, rv_pkg::OP_IMM));
    emit(enc_u(20'd0, 5'd6, rv_pkg::OP_AUIPC));
    emit(enc_i(12'd12, 5'd6, 3'b000, 5'd7, rv_pkg::OP_JALR));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, rv_pkg::OP_IMM));
    // bne taken and not taken and then on random operands
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd8, rv_pkg::OP_IMM));
    emit(enc_b(13'd8, 5'd0, 5'd8, 3'b001, rv_pkg::OP_BRANCH));
    emit(enc_i(12'd2, 5'd0, 3'b000, 5'd8, rv_pkg::OP_IMM));
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'b001, rv_pkg::OP_BRANCH));
    emit(enc_i(12'd3, 5'd8, 3'b000, 5'd8, rv_pkg::OP_IMM));
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001, rv_pkg::OP_BRANCH));
    emit(enc_i(12'd4, 5'd8, 3'b000, 5'd8, rv_pkg::OP_IMM));
    // stores with reloads in a data region based at x9 = 256
    off_w = 4 * $urandom_range(0, 61);
    off_d = 8 * $urandom_range(0, 30);
    off_r = 4 * $urandom_range(0, 63);
    emit(enc_i(12'd256, 5'd0, 3'b000, 5'd9, rv_pkg::OP_IMM));
    emit(enc_s(12'(off_w), 5'd1, 5'd9, 3'b010, rv_pkg::OP_STORE));
    emit(enc_i(12'(off_w), 5'd9, 3'b010, 5'd10, rv_pkg::OP_LOAD));
    emit(enc_s(12'(off_d), 5'd2, 5'd9, 3'b011, rv_pkg::OP_STORE));
    emit(enc_i(12'(off_d), 5'd9, 3'b010, 5'd11, rv_pkg::OP_LOAD));
    emit(enc_i(12'(off_d + 4), 5'd9, 3'b010, 5'd12, rv_pkg::OP_LOAD));
    emit(enc_i(12'(off_r), 5'd9, 3'b010, 5'd13, rv_pkg::OP_LOAD));
    repeat (4) emit_random_alu();
    emit(32'h0010_0073);
    // never reached once the core halts
    emit(enc_i(12'd1, 5'd1, 3'b000, 5'd1, rv_pkg::OP_IMM));
    emit(enc_i(12'd1, 5'd1, 3'b000, 5'd1, rv_pkg::OP_IMM));
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one-cycle read latency on both memories
  always @(posedge clk) begin
    imem_data <= rom[imem_addr[7:2]];
    if (reset) begin
      for (int i = 0; i < RAM_DW; i++) begin
        ram[i] <= fill_word(i);
      end
    end else begin
      if (dmem_re) begin
        dmem_rdata <= ram[dmem_addr[8:3]];
      end
      if (dmem_we) begin
        ram[dmem_addr[8:3]] <= (ram[dmem_addr[8:3]] & ~lane_mask(dmem_be)) |
                               (dmem_wdata & lane_mask(dmem_be));
      end
    end
  end

  always_comb begin
    m_inst      = rom[m_pc[7:2]];
    m_rd        = m_inst[11:7];
    m_a         = m_regs[m_inst[19:15]];
    m_b         = m_regs[m_inst[24:20]];
    m_imm_i     = {{52{m_inst[31]}}, m_inst[31:20]};
    m_imm_s     = {{52{m_inst[31]}}, m_inst[31:25], m_inst[11:7]};
    m_ea        = m_a + ((m_inst[6:0] == rv_pkg::OP_STORE) ? m_imm_s : m_imm_i);
    m_ld_dw     = m_ram[m_ea[8:3]];
    m_ld_w      = m_ea[2] ? m_ld_dw[63:32] : m_ld_dw[31:0];
    exp_addr    = {m_ea[63:3], 3'b000};
    exp_wr      = 1'b0;
    exp_data    = '0;
    exp_next_pc = m_pc + 64'd4;
    exp_store   = 1'b0;
    exp_be      = 8'h00;
    exp_wdata   = '0;
    exp_ebreak  = 1'b0;
    case (m_inst[6:0])
      rv_pkg::OP_LUI: begin
        exp_wr   = 1'b1;
        exp_data = {{32{m_inst[31]}}, m_inst[31:12], 12'h000};
      end
      rv_pkg::OP_AUIPC: begin
        exp_wr   = 1'b1;
        exp_data = m_pc + {{32{m_inst[31]}}, m_inst[31:12], 12'h000};
      end
      rv_pkg::OP_JAL: begin
        exp_wr      = 1'b1;
        exp_data    = m_pc + 64'd4;
        exp_next_pc = m_pc + {{44{m_inst[31]}}, m_inst[19:12], m_inst[20], m_inst[30:21], 1'b0};
      end
      rv_pkg::OP_JALR: begin
        if (m_inst[14:12] == 3'b000) begin
          exp_wr      = 1'b1;
          exp_data    = m_pc + 64'd4;
          exp_next_pc = (m_a + m_imm_i) & ~64'd1;
        end
      end
      rv_pkg::OP_BRANCH: begin
        if (m_inst[14:12] == 3'b001 && m_a != m_b) begin
          exp_next_pc = m_pc + {{52{m_inst[31]}}, m_inst[7], m_inst[30:25], m_inst[11:8], 1'b0};
        end
      end
      rv_pkg::OP_LOAD: begin
        exp_wr   = (m_inst[14:12] == 3'b010);
        exp_data = sext_word(m_ld_w);
      end
      rv_pkg::OP_STORE: begin
        exp_store = (m_inst[14:12] == 3'b010) || (m_inst[14:12] == 3'b011);
        if (m_inst[14:12] == 3'b011) begin
          exp_be    = 8'hff;
          exp_wdata = m_b;
        end else if (m_inst[14:12] == 3'b010) begin
          exp_be    = m_ea[2] ? 8'hf0 : 8'h0f;
          exp_wdata = {2{m_b[31:0]}};
        end
      end
      rv_pkg::OP_IMM: begin
        exp_wr   = (m_inst[14:12] == 3'b000) || (m_inst[14:12] == 3'b011);
        exp_data = (m_inst[14:12] == 3'b011) ? {63'd0, m_a < m_imm_i} : m_a + m_imm_i;
      end
      rv_pkg::OP_IMM32: begin
        exp_wr   = (m_inst[14:12] == 3'b000);
        exp_data = sext_word(m_a[31:0] + m_imm_i[31:0]);
      end
      rv_pkg::OP_REG: begin
        exp_wr   = (m_inst[14:12] == 3'b000) &&
                   (m_inst[31:25] == 7'h00 || m_inst[31:25] == 7'h20);
        exp_data = (m_inst[31:25] == 7'h20) ? m_a - m_b : m_a + m_b;
      end
      rv_pkg::OP_REG32: begin
        exp_wr   = (m_inst[14:12] == 3'b000) && (m_inst[31:25] == 7'h00);
        exp_data = sext_word(m_a[31:0] + m_b[31:0]);
      end
      rv_pkg::OP_SYSTEM: begin
        exp_ebreak = (m_inst == 32'h0010_0073);
      end
      default: begin
      end
    endcase
  end

  assign exp_wb_en = exp_wr && (m_rd != 5'd0);

  // the model steps once per retire pulse
  always @(posedge clk) begin
    if (reset) begin
      m_pc     <= RESET_PC;
      m_halted <= 1'b0;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
      for (int i = 0; i < RAM_DW; i++) begin
        m_ram[i] <= fill_word(i);
      end
    end else if (retire && !m_halted) begin
      m_pc    <= exp_next_pc;
      retired <= retired + 1;
      if (exp_wb_en) begin
        m_regs[m_rd] <= exp_data;
      end
      if (exp_store) begin
        m_ram[m_ea[8:3]] <= (m_ram[m_ea[8:3]] & ~lane_mask(exp_be)) |
                            (exp_wdata & lane_mask(exp_be));
      end
      if (exp_ebreak) begin
        m_halted <= 1'b1;
      end
    end
  end

  // the fetch address follows the model pc in every cycle
  a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
    imem_addr == m_pc)
    else flag_mismatch("o_imem_addr", $sampled(imem_addr), $sampled(m_pc));

  a_retire_pc: assert property (@(posedge clk) disable iff (reset)
    retire |-> (retire_pc == m_pc))
    else flag_mismatch("o_retire_pc", $sampled(retire_pc), $sampled(m_pc));

  a_wb_en: assert property (@(posedge clk) disable iff (reset)
    retire |-> (wb_en == exp_wb_en))
    else flag_mismatch("o_wb_en", 64'($sampled(wb_en)), 64'($sampled(exp_wb_en)));

  a_wb_rd: assert property (@(posedge clk) disable iff (reset)
    (retire && exp_wb_en) |-> (wb_rd == m_rd))
    else flag_mismatch("o_wb_rd", 64'($sampled(wb_rd)), 64'($sampled(m_rd)));

  a_wb_data: assert property (@(posedge clk) disable iff (reset)
    (retire && exp_wb_en) |-> (wb_data == exp_data))
    else flag_mismatch("o_wb_data", $sampled(wb_data), $sampled(exp_data));

  a_mem_addr: assert property (@(posedge clk) disable iff (reset)
    (dmem_we || dmem_re) |-> (dmem_addr == exp_addr))
    else flag_mismatch("o_dmem_addr", $sampled(dmem_addr), $sampled(exp_addr));

  a_store_be: assert property (@(posedge clk) disable iff (reset)
    dmem_we |-> (dmem_be == exp_be))
    else flag_mismatch("o_dmem_be", 64'($sampled(dmem_be)), 64'($sampled(exp_be)));

  // only enabled lanes have to carry the store data
  a_store_data: assert property (@(posedge clk) disable iff (reset)
    dmem_we |-> ((dmem_wdata & lane_mask(exp_be)) == (exp_wdata & lane_mask(exp_be))))
    else flag_mismatch("o_dmem_wdata", $sampled(dmem_wdata), $sampled(exp_wdata));

  a_halt_rise: assert property (@(posedge clk) disable iff (reset)
    (retire && exp_ebreak) |-> halt)
    else note_failure("o_halt stayed low on the ebreak retire");

  a_halt_stay: assert property (@(posedge clk) disable iff (reset)
    m_halted |-> (halt && !retire))
    else note_failure("core dropped o_halt or retired again after ebreak");

  initial begin
    reset = 1'b1;
    void'($urandom(SEED));
    build_program();
    prog_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    wait (halt);
    // window in which a stray retire would show up
    repeat (8) @(posedge clk);
    assert (m_halted) else note_failure("reference model never reached ebreak");
    for (int i = 0; i < RAM_DW; i++) begin
      assert (ram[i] == m_ram[i])
        else flag_mismatch($sformatf("ram[%0d]", i), ram[i], m_ram[i]);
    end
    $display("tb_rv_core: %0d instructions retired, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // each instruction needs at most 4 cycles
  initial begin
    wait (prog_ready);
    repeat (RESET_CYCLES + prog_len * 4 + 50) @(posedge clk);
    $display("timeout: core did not halt within %0d cycles after reset", prog_len * 4 + 50);
    $display("tb_rv_core: %0d instructions retired, %0d errors", retired, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/rv_pkg.sv
logic/rv_idu.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_lsu.sv
logic/rv_pc_unit.sv
logic/rv_ctrl_fsm.sv
logic/rv_core.sv
tb/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

sim:
	verilator --binary --assert --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
